// ==== sources.f ====
spi_pkg.sv
spi_input_sync.sv
spi_slave_shifter.sv
spi_frame_decoder.sv
spi_reg_bank.sv
spi_reg_slave_top.sv
tb_spi_reg_slave.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the spi register slave testbench with verilator
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log" build.log

verilator --binary --timing --assert -f sources.f --top-module tb_spi_reg_slave \
    -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"

# the log decides pass or fail
if grep -q "CHECKS FAILED" "$log"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
exit 0

// ==== tb_spi_reg_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_spi_reg_slave import spi_pkg::*; ();

    localparam int clk_period = 8;
    localparam int half_clks  = 5;  // sclk half-period in clk cycles
    localparam int read_bytes = 5;  // command, turnaround, value three times
    localparam int rand_ops   = 24; // interleaved random frames
    // frame count over all tests, and clk per frame incl. cs setup and gap
    localparam int num_frames = 4 * num_regs + 3 + rand_ops;
    localparam int frame_clks = (3 + 2 * data_width * read_bytes) * half_clks;
    localparam int timeout_ns = 2 * num_frames * frame_clks * clk_period + 1000;

    logic   clk;
    logic   rst;
    logic   sclk;
    logic   mosi;
    logic   cs;
    logic   miso;
    integer seed;

    logic [data_width-1:0] model  [num_regs];   // expected register contents
    logic [data_width-1:0] tx_buf [read_bytes]; // bytes the master sends
    logic [data_width-1:0] rx_buf [read_bytes]; // bytes seen on miso

    spi_reg_slave_top u_spi_reg_slave_top (
        .clk  (clk),
        .rst  (rst),
        .sclk (sclk),
        .mosi (mosi),
        .cs   (cs),
        .miso (miso)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // watchdog sized from the frame count above
    initial begin
        #(timeout_ns);
        $display("watchdog timeout, the test sequence did not finish in time");
        $display("CHECKS FAILED");
        $fatal(1);
    end

    //////////////////////////////
    // spi master model
    //////////////////////////////
    task automatic wait_clks(input int n);
        repeat (n) @(negedge clk); // inputs always move on the falling clk edge
    endtask

    // mode 1 byte, msb first; nbits below 8 cuts it short
    task automatic xfer_byte(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
        logic [7:0] sh;
        sh = tx;
        rx = '0;
        repeat (nbits) begin
            sclk = 1'b1;
            mosi = sh[data_width-1]; // master shifts out on rising sclk
            sh   = sh << 1;
            wait_clks(half_clks);
            sclk = 1'b0;
            rx   = {rx[data_width-2:0], miso}; // miso settled 4 clk after the rise
            wait_clks(half_clks);
        end
    endtask

    task automatic run_frame(input int nbytes, input int last_bits);
        cs = 1'b0;
        wait_clks(half_clks); // cs setup before the first edge
        for (int b = 0; b < nbytes; b++) begin
            xfer_byte(tx_buf[b], (b == nbytes - 1) ? last_bits : data_width, rx_buf[b]);
        end
        cs = 1'b1;
        wait_clks(2 * half_clks); // short deselect gap
    endtask

    //////////////////////////////
    // checks and register access
    //////////////////////////////
    task automatic check_byte(input int idx, input logic [7:0] exp, input logic [7:0] got);
        assert (got === exp) else begin
            $display("[ERROR] miso byte %0d: expected 0x%h, got 0x%h", idx, exp, got);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic write_reg(input logic [addr_width-1:0] addr, input logic [7:0] data,
                             input int nbytes, input int last_bits);
        int rnd;
        rnd       = $random(seed);
        tx_buf[0] = {1'b1, rnd[6:4], addr}; // bits 6..4 random, must not matter
        tx_buf[1] = data;
        for (int b = 2; b < read_bytes; b++) begin
            rnd       = $random(seed);
            tx_buf[b] = rnd[7:0]; // trailing junk
        end
        run_frame(nbytes, last_bits);
        check_byte(0, 8'h00, rx_buf[0]);
        if (last_bits == data_width) begin
            check_byte(1, 8'h00, rx_buf[1]);
            model[addr] = data; // cut data byte leaves the register alone
        end
    endtask

    task automatic read_reg(input logic [addr_width-1:0] addr);
        int rnd;
        rnd       = $random(seed);
        tx_buf[0] = {1'b0, rnd[6:4], addr};
        for (int b = 1; b < read_bytes; b++) begin
            rnd       = $random(seed);
            tx_buf[b] = rnd[7:0]; // mosi is don't-care after the command
        end
        run_frame(read_bytes, data_width);
        check_byte(0, 8'h00, rx_buf[0]);
        check_byte(1, 8'h00, rx_buf[1]);
        for (int b = 2; b < read_bytes; b++) begin
            check_byte(b, model[addr], rx_buf[b]); // value repeats to the end
        end
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////
    initial begin
        int                    rnd;
        logic [addr_width-1:0] addr;
        seed = 32'he55;
        rst  = 1'b1;
        sclk = 1'b0;
        mosi = 1'b0;
        cs   = 1'b1;
        for (int a = 0; a < num_regs; a++)
            model[a] = '0;
        wait_clks(5);
        rst = 1'b0;
        wait_clks(4);

        // all registers clear out of reset
        for (int a = 0; a < num_regs; a++)
            read_reg(addr_width'(a));

        // fill with random values, then read back
        for (int a = 0; a < num_regs; a++) begin
            rnd = $random(seed);
            write_reg(addr_width'(a), rnd[7:0], 2, data_width);
        end
        for (int a = 0; a < num_regs; a++)
            read_reg(addr_width'(a));

        addr = 4'd5;
        write_reg(addr, ~model[addr], 2, 4); // cs rises after 4 data bits
        read_reg(addr);

        addr = 4'd9;
        write_reg(addr, ~model[addr], read_bytes, data_width); // extra bytes after data
        for (int a = 0; a < num_regs; a++)
            read_reg(addr_width'(a));

        // back to back mix of reads and writes
        for (int n = 0; n < rand_ops; n++) begin
            rnd  = $random(seed);
            addr = rnd[11:8];
            if (rnd[0])
                write_reg(addr, rnd[23:16], 2, data_width);
            else
                read_reg(addr);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== spi_reg_slave_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module spi_reg_slave_top import spi_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic sclk,
    input  logic mosi,
    input  logic cs,
    output logic miso
);

    //////////////////////////////
    // stage links
    //////////////////////////////
    spi_evt_t              evt;     // sync to shifter
    rx_byte_t              rx;      // shifter to decoder
    reg_req_t              req;     // decoder to bank
    reg_rsp_t              rsp;     // bank back to decoder
    logic [data_width-1:0] tx_byte; // decoder back to shifter

    spi_input_sync u_sync (
        .clk  (clk),
        .rst  (rst),
        .sclk (sclk),
        .mosi (mosi),
        .cs   (cs),
        .evt  (evt)
    );

    spi_slave_shifter u_shifter (
        .clk     (clk),
        .rst     (rst),
        .evt     (evt),
        .tx_byte (tx_byte),
        .rx      (rx),
        .miso    (miso)
    );

    spi_frame_decoder u_decoder (
        .clk     (clk),
        .rst     (rst),
        .rx      (rx),
        .rsp     (rsp),
        .req     (req),
        .tx_byte (tx_byte)
    );

    spi_reg_bank u_regs (
        .clk (clk),
        .rst (rst),
        .req (req),
        .rsp (rsp)
    );

endmodule

`default_nettype wire

// ==== spi_reg_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module spi_reg_bank import spi_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_req_t req,
    output reg_rsp_t rsp
);

    logic [data_width-1:0] regs [num_regs];
    logic                  rsp_valid;
    logic [data_width-1:0] rsp_rdata;

    // register file, all cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req.rd; // answer one clk after the strobe
            if (req.wr) begin
                regs[req.addr] <= req.wdata;
            end
        end
    end

    // read data register
    always_ff @(posedge clk) begin
        if (req.rd) rsp_rdata <= regs[req.addr];
    end

    assign rsp = '{valid: rsp_valid, rdata: rsp_rdata};

endmodule

`default_nettype wire

// ==== spi_frame_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module spi_frame_decoder import spi_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  rx_byte_t              rx,
    input  reg_rsp_t              rsp,
    output reg_req_t              req,
    output logic [data_width-1:0] tx_byte
);

    logic [1:0]            byte_idx;  // 0 command, 1 data or turnaround, 2 and up the rest
    logic                  cmd_wr;    // bit 7 of the command
    logic [addr_width-1:0] cmd_addr;
    logic                  req_wr;
    logic                  req_rd;
    logic [data_width-1:0] req_wdata;
    logic                  is_cmd;
    logic                  is_data;

    assign is_cmd  = rx.valid && (byte_idx == 2'd0);
    assign is_data = rx.valid && (byte_idx == 2'd1);

    //////////////////////////////
    // command and data latch
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (is_cmd) begin
            cmd_wr   <= rx.data[data_width-1];
            cmd_addr <= rx.data[addr_width-1:0]; // bits 6..4 dropped here
        end
        if (is_data) begin
            req_wdata <= rx.data;
        end
    end

    //////////////////////////////
    // byte index and strobes
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            byte_idx <= 2'd0;
            req_wr   <= 1'b0;
            req_rd   <= 1'b0;
            tx_byte  <= '0;
        end else begin
            req_wr <= 1'b0;
            req_rd <= 1'b0;
            if (rx.frame_start) begin
                byte_idx <= 2'd0;
                tx_byte  <= '0; // turnaround byte sends zero
            end else begin
                if (rsp.valid) tx_byte <= rsp.rdata; // held for bytes 2 and later
                if (rx.valid && byte_idx != 2'd2) begin
                    byte_idx <= byte_idx + 2'd1; // saturate, later bytes all look alike
                end
                if (is_cmd && !rx.data[data_width-1]) begin
                    req_rd <= 1'b1; // read fetched during turnaround byte
                end
                if (is_data && cmd_wr) begin
                    req_wr <= 1'b1;
                end
            end
        end
    end

    // cmd_addr is valid in the rd cycle and stays so through the wr cycle
    assign req = '{wr: req_wr, rd: req_rd, addr: cmd_addr, wdata: req_wdata};

endmodule

`default_nettype wire

// ==== spi_slave_shifter.sv ====
`timescale 1ns/1ns
`default_nettype none

module spi_slave_shifter import spi_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  spi_evt_t              evt,
    input  logic [data_width-1:0] tx_byte,
    output rx_byte_t              rx,
    output logic                  miso
);

    typedef enum logic [1:0] {
        st_idle,    // waiting for cs low
        st_wait_hi, // waiting for sclk rise, drive miso there
        st_wait_lo  // waiting for sclk fall, sample mosi there
    } state_t;

    state_t                   state;
    logic                     sel;       // index of the working buffer
    logic [data_width-1:0]    shreg [2]; // one shifts, the other preloads tx_byte
    logic [bit_cnt_width-1:0] bit_cnt;
    logic                     rx_valid;
    logic                     rx_start;
    logic [data_width-1:0]    rx_data;
    logic [data_width-1:0]    shifted;   // working buffer with the new bit in
    logic                     frame_go;
    logic                     shift_en;
    logic                     byte_done;

    assign shifted   = {shreg[sel][data_width-2:0], evt.mosi_s};
    assign frame_go  = (state == st_idle) && evt.cs_fall;
    assign shift_en  = (state == st_wait_lo) && evt.sclk_fall && !evt.cs_rise;
    assign byte_done = shift_en && (bit_cnt == last_bit);

    //////////////////////////////
    // double buffer
    //////////////////////////////
    always_ff @(posedge clk) begin
        shreg[~sel] <= tx_byte; // idle buffer tracks the next byte to send
        if (frame_go) begin
            shreg[~sel] <= '0; // becomes working, byte 0 has nothing to answer
        end else if (shift_en && !byte_done) begin
            shreg[sel] <= shifted;
        end
    end

    always_ff @(posedge clk) begin
        if (byte_done) rx_data <= shifted; // full byte straight from the shift path
    end

    //////////////////////////////
    // bit engine
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            sel      <= 1'b0;
            bit_cnt  <= '0;
            miso     <= 1'b0;
            rx_valid <= 1'b0;
            rx_start <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            rx_start <= 1'b0;
            if (state != st_idle && evt.cs_rise) begin
                // frame over, partial byte is simply lost
                state   <= st_idle;
                bit_cnt <= '0;
                miso    <= 1'b0;
            end else begin
                case (state)
                    st_idle: if (evt.cs_fall) begin
                        rx_start <= 1'b1;
                        sel      <= ~sel; // preloaded buffer goes to work
                        bit_cnt  <= '0;
                        state    <= st_wait_hi;
                    end
                    st_wait_hi: if (evt.sclk_rise) begin
                        miso  <= shreg[sel][data_width-1]; // msb first
                        state <= st_wait_lo;
                    end
                    st_wait_lo: if (evt.sclk_fall) begin
                        state <= st_wait_hi;
                        if (byte_done) begin
                            rx_valid <= 1'b1;
                            sel      <= ~sel;
                            bit_cnt  <= '0;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    assign rx = '{valid: rx_valid, data: rx_data, frame_start: rx_start};

endmodule

`default_nettype wire

// ==== spi_input_sync.sv ====
`timescale 1ns/1ns
`default_nettype none

module spi_input_sync import spi_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     sclk,
    input  logic     mosi,
    input  logic     cs,
    output spi_evt_t evt
);

    // [0] and [1] form the synchronizer, [2] is the delayed copy for edges
    logic [2:0] sclk_sr;
    logic [2:0] cs_sr;
    logic [1:0] mosi_sr; // no edge needed on mosi, level only

    always_ff @(posedge clk) begin
        if (rst) begin
            sclk_sr <= 3'b000; // mode 1 idles low
            cs_sr   <= 3'b111; // slave deselected
            mosi_sr <= 2'b00;
            evt     <= '0;
        end else begin
            sclk_sr <= {sclk_sr[1:0], sclk};
            cs_sr   <= {cs_sr[1:0], cs};
            mosi_sr <= {mosi_sr[0], mosi};

            // edge strobes are registered, 3 clk after the pin moves
            evt.sclk_rise <= sclk_sr[1] & ~sclk_sr[2];
            evt.sclk_fall <= ~sclk_sr[1] & sclk_sr[2];
            evt.cs_fall   <= ~cs_sr[1] & cs_sr[2];
            evt.cs_rise   <= cs_sr[1] & ~cs_sr[2];
            evt.mosi_s    <= mosi_sr[1]; // same depth as the sclk stage feeding the edge
        end
    end

endmodule

`default_nettype wire

// ==== spi_pkg.sv ====
`default_nettype none

package spi_pkg;

    //////////////////////////////
    // widths and counts
    //////////////////////////////
    localparam int data_width    = 8;                  // spi word
    localparam int num_regs      = 16;                 // register bank depth
    localparam int addr_width    = $clog2(num_regs);   // 4 address bits
    localparam int bit_cnt_width = $clog2(data_width); // counts 0..7 in a byte
    localparam logic [bit_cnt_width-1:0] last_bit = bit_cnt_width'(data_width - 1);

    //////////////////////////////
    // stage structs
    //////////////////////////////

    // synchronized pin events, one clk wide each
    typedef struct packed {
        logic sclk_rise;
        logic sclk_fall;
        logic cs_fall;
        logic cs_rise;
        logic mosi_s;     // mosi level aligned with the edge strobes
    } spi_evt_t;

    // received byte from the shifter
    typedef struct packed {
        logic                  valid;       // byte complete
        logic [data_width-1:0] data;
        logic                  frame_start; // cs went low
    } rx_byte_t;

    // register command from the decoder
    typedef struct packed {
        logic                  wr;
        logic                  rd;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
    } reg_req_t;

    // read answer from the bank
    typedef struct packed {
        logic                  valid;
        logic [data_width-1:0] rdata;
    } reg_rsp_t;

endpackage

`default_nettype wire
